//--- rtl/vera_defines.svh
// Video controller register map and timing
`ifndef VERA_DEFINES_SVH
`define VERA_DEFINES_SVH

// Register offsets inside the register region
`define VERA_REG_BORDER    6'h01
`define VERA_REG_IEN       6'h02
`define VERA_REG_ISR       6'h03
`define VERA_REG_IRQLINE   6'h04
`define VERA_REG_SCANLINE  6'h05
`define VERA_REG_VIDEO     6'h06
`define VERA_REG_HSTART    6'h0A
`define VERA_REG_HSTOP     6'h0B
`define VERA_REG_VSTART    6'h0C
`define VERA_REG_VSTOP     6'h0D

// Bus regions, word addresses
`define VERA_REG_END       17'h00400
`define VERA_PAL_START     17'h00800
`define VERA_PAL_END       17'h00900

// 640x480 line and frame timing in pixels and lines
`define VERA_H_ACTIVE      10'd640
`define VERA_H_SYNC_START  10'd656
`define VERA_H_SYNC_END    10'd752
`define VERA_H_TOTAL       10'd800
`define VERA_V_ACTIVE      10'd480
`define VERA_V_SYNC_START  10'd490
`define VERA_V_SYNC_END    10'd492
`define VERA_V_TOTAL       10'd525

`define VERA_HSTOP_RESET   10'd640
`define VERA_VSTOP_RESET   10'd480

`endif

//--- rtl/vera_pkg.sv
// Video controller shared types
package vera_pkg;

    // Wishbone word address and data
    typedef logic [16:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // Offset inside the register region
    typedef logic [5:0] reg_addr_t;

    typedef logic [7:0] color_idx_t;

    // Red in 11:8, green in 7:4, blue in 3:0
    typedef logic [11:0] rgb_t;

    typedef logic [9:0] hpos_t;
    typedef logic [9:0] vpos_t;

    // Codes 2 and 3 behave like off
    typedef enum logic [1:0] {
        VIDEO_OFF = 2'd0,
        VIDEO_VGA = 2'd1
    } out_mode_e;

endpackage

//--- rtl/vera_bus_if.sv
// Decoded register and palette access
`timescale 1ns/100ps

interface vera_bus_if;

    logic                 reg_wr;
    logic                 pal_wr;
    vera_pkg::color_idx_t idx;
    vera_pkg::wb_data_t   wdata;
    logic [3:0]           sel;
    // Register read data, combinational from idx
    vera_pkg::wb_data_t   rdata;

    modport master_mp (
        output reg_wr, pal_wr, idx, wdata, sel,
        input  rdata
    );

    modport slave_mp (
        input  reg_wr, pal_wr, idx, wdata, sel,
        output rdata
    );

endinterface

//--- rtl/vera_wb_slave.sv
// Pipelined Wishbone slave
`timescale 1ns/100ps
`include "vera_defines.svh"

module vera_wb_slave (
    input  logic               clk,
    input  logic               reset,
    input  vera_pkg::wb_addr_t wb_adr_i,
    input  vera_pkg::wb_data_t wb_dat_w_i,
    input  logic [3:0]         wb_sel_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    output vera_pkg::wb_data_t wb_dat_r_o,
    output logic               wb_ack_o,
    output logic               wb_stall_o,
    vera_bus_if.master_mp      bus
);

    logic               accept;
    logic               in_reg;
    logic               in_pal;
    logic               ack_r;
    vera_pkg::wb_data_t dat_r_r;

    // Region decode
    assign in_reg = wb_adr_i < `VERA_REG_END;
    assign in_pal = (wb_adr_i >= `VERA_PAL_START) && (wb_adr_i < `VERA_PAL_END);

    // Every access finishes in the next cycle, so a new strobe is always taken
    assign wb_stall_o = 1'b0;
    assign accept     = wb_cyc_i && wb_stb_i && !wb_stall_o;

    // Write pulses land on the acceptance edge
    assign bus.reg_wr = accept && wb_we_i && in_reg;
    assign bus.pal_wr = accept && wb_we_i && in_pal;
    assign bus.idx    = wb_adr_i[7:0];
    assign bus.wdata  = wb_dat_w_i;
    assign bus.sel    = wb_sel_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= accept;
        end
    end

    // Palette and unmapped space read as zero
    always_ff @(posedge clk) begin
        if (accept) begin
            dat_r_r <= (in_reg && !wb_we_i) ? bus.rdata : '0;
        end
    end

    assign wb_ack_o   = ack_r;
    assign wb_dat_r_o = dat_r_r;

endmodule

//--- rtl/vera_regs.sv
// Control and interrupt registers
`timescale 1ns/100ps
`include "vera_defines.svh"

module vera_regs (
    input  logic                 clk,
    input  logic                 reset,
    vera_bus_if.slave_mp         bus,
    input  logic                 vblank_pulse_i,
    input  logic                 line_pulse_i,
    input  vera_pkg::vpos_t      scanline_i,
    output vera_pkg::color_idx_t border_o,
    output vera_pkg::hpos_t      hstart_o,
    output vera_pkg::hpos_t      hstop_o,
    output vera_pkg::vpos_t      vstart_o,
    output vera_pkg::vpos_t      vstop_o,
    output vera_pkg::vpos_t      irq_line_o,
    output vera_pkg::out_mode_e  mode_o,
    output logic                 irq_n_o
);

    vera_pkg::reg_addr_t offset;
    // Bit 0 vsync, bit 1 line
    logic [1:0] ien_r;
    logic [1:0] isr_r;
    logic [1:0] isr_set;
    logic [1:0] isr_next;

    assign offset  = bus.idx[5:0];
    assign isr_set = {line_pulse_i, vblank_pulse_i};

    //////////////////////////////////////////////////
    // Interrupt status
    //////////////////////////////////////////////////

    // Write 1 clears, a new event in the same cycle wins
    always_comb begin
        isr_next = isr_r;
        if (bus.reg_wr && (offset == `VERA_REG_ISR)) begin
            isr_next = isr_r & ~bus.wdata[1:0];
        end
        isr_next = isr_next | isr_set;
    end

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            border_o   <= '0;
            ien_r      <= '0;
            isr_r      <= '0;
            irq_line_o <= '0;
            mode_o     <= vera_pkg::VIDEO_OFF;
            hstart_o   <= '0;
            hstop_o    <= `VERA_HSTOP_RESET;
            vstart_o   <= '0;
            vstop_o    <= `VERA_VSTOP_RESET;
            irq_n_o    <= 1'b1;
        end else begin
            isr_r   <= isr_next;
            irq_n_o <= ~|(isr_r & ien_r);
            if (bus.reg_wr) begin
                case (offset)
                    `VERA_REG_BORDER:  border_o   <= bus.wdata[7:0];
                    `VERA_REG_IEN:     ien_r      <= bus.wdata[1:0];
                    `VERA_REG_IRQLINE: irq_line_o <= bus.wdata[9:0];
                    `VERA_REG_VIDEO:   mode_o     <= vera_pkg::out_mode_e'(bus.wdata[1:0]);
                    `VERA_REG_HSTART:  hstart_o   <= bus.wdata[9:0];
                    `VERA_REG_HSTOP:   hstop_o    <= bus.wdata[9:0];
                    `VERA_REG_VSTART:  vstart_o   <= bus.wdata[9:0];
                    `VERA_REG_VSTOP:   vstop_o    <= bus.wdata[9:0];
                    default: begin
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    always_comb begin
        case (offset)
            `VERA_REG_BORDER:   bus.rdata = {24'b0, border_o};
            `VERA_REG_IEN:      bus.rdata = {30'b0, ien_r};
            `VERA_REG_ISR:      bus.rdata = {30'b0, isr_r};
            `VERA_REG_IRQLINE:  bus.rdata = {22'b0, irq_line_o};
            // Read-only, current line from the timing generator
            `VERA_REG_SCANLINE: bus.rdata = {22'b0, scanline_i};
            `VERA_REG_VIDEO:    bus.rdata = {30'b0, mode_o};
            `VERA_REG_HSTART:   bus.rdata = {22'b0, hstart_o};
            `VERA_REG_HSTOP:    bus.rdata = {22'b0, hstop_o};
            `VERA_REG_VSTART:   bus.rdata = {22'b0, vstart_o};
            `VERA_REG_VSTOP:    bus.rdata = {22'b0, vstop_o};
            default:            bus.rdata = '0;
        endcase
    end

endmodule

//--- rtl/palette_ram.sv
// Colour palette memory
`timescale 1ns/100ps

module palette_ram (
    input  logic                 clk,
    vera_bus_if.slave_mp         bus,
    input  vera_pkg::color_idx_t rd_idx_i,
    output vera_pkg::rgb_t       rd_rgb_o
);

    vera_pkg::rgb_t mem [0:255];

    // Byte lane 0 carries green and blue, lane 1 carries red
    always_ff @(posedge clk) begin
        if (bus.pal_wr && bus.sel[0]) begin
            mem[bus.idx][7:0] <= bus.wdata[7:0];
        end
        if (bus.pal_wr && bus.sel[1]) begin
            mem[bus.idx][11:8] <= bus.wdata[11:8];
        end
    end

    // Composer side, one clk read latency
    always_ff @(posedge clk) begin
        rd_rgb_o <= mem[rd_idx_i];
    end

endmodule

//--- rtl/video_timing.sv
// VGA timing generator
`timescale 1ns/100ps
`include "vera_defines.svh"

module video_timing (
    input  logic            clk,
    input  logic            reset,
    input  vera_pkg::vpos_t irq_line_i,
    output logic            pix_en_o,
    output vera_pkg::hpos_t hpos_o,
    output vera_pkg::vpos_t vpos_o,
    output logic            hsync_n_o,
    output logic            vsync_n_o,
    output logic            vblank_pulse_o,
    output logic            line_pulse_o
);

    logic            h_last;
    logic            v_last;
    logic            line_step;
    vera_pkg::vpos_t v_next;

    assign h_last    = hpos_o == (`VERA_H_TOTAL - 10'd1);
    assign v_last    = vpos_o == (`VERA_V_TOTAL - 10'd1);
    assign v_next    = v_last ? '0 : vpos_o + 10'd1;
    assign line_step = pix_en_o && h_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_en_o       <= 1'b0;
            hpos_o         <= '0;
            vpos_o         <= '0;
            vblank_pulse_o <= 1'b0;
            line_pulse_o   <= 1'b0;
        end else begin
            // Pixel rate is half of clk
            pix_en_o <= ~pix_en_o;

            // Events are high for the first clk of the new line
            vblank_pulse_o <= line_step && (v_next == `VERA_V_ACTIVE);
            line_pulse_o   <= line_step && (v_next == irq_line_i);

            if (pix_en_o) begin
                if (h_last) begin
                    hpos_o <= '0;
                    vpos_o <= v_next;
                end else begin
                    hpos_o <= hpos_o + 10'd1;
                end
            end
        end
    end

    // Active low inside the sync ranges
    assign hsync_n_o = !((hpos_o >= `VERA_H_SYNC_START) && (hpos_o < `VERA_H_SYNC_END));
    assign vsync_n_o = !((vpos_o >= `VERA_V_SYNC_START) && (vpos_o < `VERA_V_SYNC_END));

endmodule

//--- rtl/display_composer.sv
// Border and window composer with VGA output
`timescale 1ns/100ps
`include "vera_defines.svh"

module display_composer (
    input  logic                 clk,
    input  logic                 reset,
    input  vera_pkg::hpos_t      hpos_i,
    input  vera_pkg::vpos_t      vpos_i,
    input  logic                 hsync_n_i,
    input  logic                 vsync_n_i,
    input  vera_pkg::color_idx_t border_i,
    input  vera_pkg::hpos_t      hstart_i,
    input  vera_pkg::hpos_t      hstop_i,
    input  vera_pkg::vpos_t      vstart_i,
    input  vera_pkg::vpos_t      vstop_i,
    input  vera_pkg::out_mode_e  mode_i,
    output vera_pkg::color_idx_t pal_idx_o,
    input  vera_pkg::rgb_t       pal_rgb_i,
    output logic [3:0]           vga_r_o,
    output logic [3:0]           vga_g_o,
    output logic [3:0]           vga_b_o,
    output logic                 vga_hsync_o,
    output logic                 vga_vsync_o
);

    logic       in_window;
    logic       visible;
    logic [1:0] visible_d;
    logic [1:0] hsync_d;
    logic [1:0] vsync_d;

    assign in_window = (hpos_i >= hstart_i) && (hpos_i < hstop_i) &&
                       (vpos_i >= vstart_i) && (vpos_i < vstop_i);
    assign visible   = (hpos_i < `VERA_H_ACTIVE) && (vpos_i < `VERA_V_ACTIVE);

    // Stage 1, palette index. Entry 0 fills the window
    always_ff @(posedge clk) begin
        pal_idx_o <= in_window ? 8'h00 : border_i;
    end

    // Syncs and visible flag match the index stage and palette read
    always_ff @(posedge clk) begin
        if (reset) begin
            visible_d <= '0;
            hsync_d   <= '1;
            vsync_d   <= '1;
        end else begin
            visible_d <= {visible_d[0], visible};
            hsync_d   <= {hsync_d[0], hsync_n_i};
            vsync_d   <= {vsync_d[0], vsync_n_i};
        end
    end

    // Stage 3, output pins
    always_ff @(posedge clk) begin
        if (reset || (mode_i != vera_pkg::VIDEO_VGA)) begin
            {vga_r_o, vga_g_o, vga_b_o} <= 12'h000;
            vga_hsync_o                 <= 1'b0;
            vga_vsync_o                 <= 1'b0;
        end else begin
            {vga_r_o, vga_g_o, vga_b_o} <= visible_d[1] ? pal_rgb_i : 12'h000;
            vga_hsync_o                 <= hsync_d[1];
            vga_vsync_o                 <= vsync_d[1];
        end
    end

endmodule

//--- rtl/vera_top.sv
// Display controller top level
`timescale 1ns/100ps

module vera_top (
    input  logic               clk,
    input  logic               reset,
    input  vera_pkg::wb_addr_t wb_adr_i,
    input  vera_pkg::wb_data_t wb_dat_w_i,
    input  logic [3:0]         wb_sel_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    output vera_pkg::wb_data_t wb_dat_r_o,
    output logic               wb_ack_o,
    output logic               wb_stall_o,
    output logic               wb_err_o,
    output logic               irq_n_o,
    output logic [3:0]         vga_r_o,
    output logic [3:0]         vga_g_o,
    output logic [3:0]         vga_b_o,
    output logic               vga_hsync_o,
    output logic               vga_vsync_o
);

    vera_pkg::hpos_t      hpos;
    vera_pkg::vpos_t      vpos;
    logic                 hsync_n;
    logic                 vsync_n;
    logic                 vblank_pulse;
    logic                 line_pulse;
    vera_pkg::color_idx_t border;
    vera_pkg::hpos_t      hstart;
    vera_pkg::hpos_t      hstop;
    vera_pkg::vpos_t      vstart;
    vera_pkg::vpos_t      vstop;
    vera_pkg::vpos_t      irq_line;
    vera_pkg::out_mode_e  mode;
    vera_pkg::color_idx_t pal_idx;
    vera_pkg::rgb_t       pal_rgb;

    vera_bus_if bus ();

    // No access ends in an error
    assign wb_err_o = 1'b0;

    //////////////////////////////////////////////////
    // Bus side
    //////////////////////////////////////////////////

    vera_wb_slave u_wb_slave (
        .clk, .reset,
        .wb_adr_i, .wb_dat_w_i, .wb_sel_i,
        .wb_cyc_i, .wb_stb_i, .wb_we_i,
        .wb_dat_r_o, .wb_ack_o, .wb_stall_o,
        .bus        (bus.master_mp)
    );

    vera_regs u_regs (
        .clk, .reset,
        .bus            (bus.slave_mp),
        .vblank_pulse_i (vblank_pulse),
        .line_pulse_i   (line_pulse),
        .scanline_i     (vpos),
        .border_o       (border),
        .hstart_o       (hstart),
        .hstop_o        (hstop),
        .vstart_o       (vstart),
        .vstop_o        (vstop),
        .irq_line_o     (irq_line),
        .mode_o         (mode),
        .irq_n_o
    );

    palette_ram u_palette (
        .clk,
        .bus      (bus.slave_mp),
        .rd_idx_i (pal_idx),
        .rd_rgb_o (pal_rgb)
    );

    //////////////////////////////////////////////////
    // Video side
    //////////////////////////////////////////////////

    // Pixel enable is not needed outside, the composer runs every clk
    video_timing u_timing (
        .clk, .reset,
        .irq_line_i     (irq_line),
        .pix_en_o       (),
        .hpos_o         (hpos),
        .vpos_o         (vpos),
        .hsync_n_o      (hsync_n),
        .vsync_n_o      (vsync_n),
        .vblank_pulse_o (vblank_pulse),
        .line_pulse_o   (line_pulse)
    );

    display_composer u_composer (
        .clk, .reset,
        .hpos_i    (hpos),
        .vpos_i    (vpos),
        .hsync_n_i (hsync_n),
        .vsync_n_i (vsync_n),
        .border_i  (border),
        .hstart_i  (hstart),
        .hstop_i   (hstop),
        .vstart_i  (vstart),
        .vstop_i   (vstop),
        .mode_i    (mode),
        .pal_idx_o (pal_idx),
        .pal_rgb_i (pal_rgb),
        .vga_r_o, .vga_g_o, .vga_b_o,
        .vga_hsync_o, .vga_vsync_o
    );

endmodule

//--- bench/vera_model.sv
// Reference model of registers and palette
`include "vera_defines.svh"

package vera_model;

    // Register image by offset, palette image by index
    vera_pkg::wb_data_t regs [64];
    vera_pkg::rgb_t     pal  [256];

    function automatic void reset_state();
        for (int i = 0; i < 64; i++) begin
            regs[i] = '0;
        end
        regs[`VERA_REG_HSTOP] = 32'd640;
        regs[`VERA_REG_VSTOP] = 32'd480;
    endfunction

    // Bits that a register keeps after a write
    function automatic vera_pkg::wb_data_t width_mask(vera_pkg::reg_addr_t off);
        case (off)
            `VERA_REG_BORDER:  return 32'h0000_00FF;
            `VERA_REG_IEN:     return 32'h0000_0003;
            `VERA_REG_VIDEO:   return 32'h0000_0003;
            `VERA_REG_IRQLINE,
            `VERA_REG_HSTART,
            `VERA_REG_HSTOP,
            `VERA_REG_VSTART,
            `VERA_REG_VSTOP:   return 32'h0000_03FF;
            default:           return 32'h0;
        endcase
    endfunction

    function automatic void write_reg(vera_pkg::reg_addr_t off, vera_pkg::wb_data_t data);
        regs[off] = data & width_mask(off);
    endfunction

    function automatic vera_pkg::wb_data_t read_reg(vera_pkg::reg_addr_t off);
        return regs[off];
    endfunction

    // Lane 0 holds green and blue, lane 1 holds red
    function automatic void write_palette(vera_pkg::color_idx_t idx,
                                          vera_pkg::wb_data_t data, logic [3:0] sel);
        if (sel[0]) begin
            pal[idx][7:0] = data[7:0];
        end
        if (sel[1]) begin
            pal[idx][11:8] = data[11:8];
        end
    endfunction

    // Expected pin colour for a pixel with VGA output on
    function automatic vera_pkg::rgb_t pixel_colour(int x, int y);
        logic                 in_win;
        vera_pkg::color_idx_t idx;
        if (x >= 640 || y >= 480) begin
            return 12'h000;
        end
        in_win = (x >= regs[`VERA_REG_HSTART]) && (x < regs[`VERA_REG_HSTOP]) &&
                 (y >= regs[`VERA_REG_VSTART]) && (y < regs[`VERA_REG_VSTOP]);
        idx = in_win ? 8'h00 : regs[`VERA_REG_BORDER][7:0];
        return pal[idx];
    endfunction

endpackage

//--- bench/tb_vera.sv
// Display controller testbench
`timescale 1ns/100ps
`include "vera_defines.svh"

module tb_vera;

    localparam int FRAME_CLKS = 800 * 525 * 2;

    logic               clk;
    logic               reset;
    vera_pkg::wb_addr_t wb_adr;
    vera_pkg::wb_data_t wb_dat_w;
    logic [3:0]         wb_sel;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    vera_pkg::wb_data_t wb_dat_r_o;
    logic               wb_ack_o;
    logic               wb_stall_o;
    logic               wb_err_o;
    logic               irq_n_o;
    logic [3:0]         vga_r_o;
    logic [3:0]         vga_g_o;
    logic [3:0]         vga_b_o;
    logic               vga_hsync_o;
    logic               vga_vsync_o;

    // Monitor state
    int             hcnt;
    int             vline;
    int             frames;
    int             checked;
    bit             h_locked;
    bit             v_locked;
    bit             check_en;
    bit             irq_watch;
    logic           prev_hs;
    logic           prev_vs;
    vera_pkg::rgb_t exp_rgb;

    vera_top UUT (
        .clk, .reset,
        .wb_adr_i (wb_adr), .wb_dat_w_i (wb_dat_w), .wb_sel_i (wb_sel),
        .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
        .wb_dat_r_o, .wb_ack_o, .wb_stall_o, .wb_err_o, .irq_n_o,
        .vga_r_o, .vga_g_o, .vga_b_o, .vga_hsync_o, .vga_vsync_o
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // Wishbone driver
    //////////////////////////////////////////////////

    task automatic bus_access(input vera_pkg::wb_addr_t adr, input logic we,
                              input vera_pkg::wb_data_t wdat, input logic [3:0] sel,
                              output vera_pkg::wb_data_t rdat);
        @(posedge clk);
        #10;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        wb_sel   = sel;
        // Hold the strobe until the slave takes it
        @(negedge clk);
        while (wb_stall_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // Ack belongs to the cycle right after acceptance
        @(negedge clk);
        assert (wb_ack_o) else report_failure("Error wb_ack_o exp 1 got 0");
        assert (!wb_err_o) else report_failure("Error wb_err_o exp 0 got 1");
        assert (!wb_stall_o) else report_failure("Error wb_stall_o exp 0 got 1");
        rdat = wb_dat_r_o;
        @(negedge clk);
        assert (!wb_ack_o) else report_failure("Acknowledge stayed high for a second cycle");
    endtask

    task automatic write_register(input vera_pkg::reg_addr_t off, input vera_pkg::wb_data_t data);
        vera_pkg::wb_data_t unused;
        bus_access({11'b0, off}, 1'b1, data, 4'hF, unused);
        vera_model::write_reg(off, data);
    endtask

    task automatic check_read(input vera_pkg::wb_addr_t adr, input vera_pkg::wb_data_t exp,
                              input string name);
        vera_pkg::wb_data_t got;
        bus_access(adr, 1'b0, '0, 4'hF, got);
        assert (got == exp) else
            report_failure($sformatf("Error %s exp %h got %h", name, exp, got));
    endtask

    //////////////////////////////////////////////////
    // Video monitor
    //////////////////////////////////////////////////

    // Hsync falls at pixel 656, vsync falls at the start of line 490
    always @(negedge clk) begin
        if (reset) begin
            h_locked = 0;
            v_locked = 0;
            prev_hs  = 0;
            prev_vs  = 0;
            hcnt     = 0;
            vline    = 0;
        end else begin
            if (prev_hs && !vga_hsync_o) begin
                hcnt     = 656 * 2;
                h_locked = 1;
            end else if (hcnt == 1599) begin
                hcnt  = 0;
                vline = (vline + 1) % 525;
            end else begin
                hcnt++;
            end
            if (prev_vs && !vga_vsync_o) begin
                vline    = 490;
                v_locked = 1;
                frames++;
            end
            prev_hs = vga_hsync_o;
            prev_vs = vga_vsync_o;
            if (check_en && h_locked && v_locked) begin
                exp_rgb = vera_model::pixel_colour(hcnt / 2, vline);
                assert ({vga_r_o, vga_g_o, vga_b_o} == exp_rgb) else
                    report_failure($sformatf("Error vga_rgb exp %h got %h at x %0d y %0d",
                                             exp_rgb, {vga_r_o, vga_g_o, vga_b_o},
                                             hcnt / 2, vline));
                checked++;
            end
            if (irq_watch) begin
                assert (irq_n_o) else
                    report_failure("Interrupt output went low while all sources were disabled");
            end
        end
    end

    // Watchdog
    initial begin
        #(100.0 * (4.0 * FRAME_CLKS + 20000.0));
        $display("Run did not finish within the expected time");
        $display("TEST FAILED");
        $fatal(1);
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        vera_pkg::reg_addr_t  writable [8];
        vera_pkg::wb_data_t   rd;
        vera_pkg::wb_data_t   data;
        vera_pkg::color_idx_t idx;
        logic [3:0]           sel;
        int                   f0;
        int                   first;
        int                   second;
        writable = '{`VERA_REG_BORDER, `VERA_REG_IEN, `VERA_REG_IRQLINE, `VERA_REG_VIDEO,
                     `VERA_REG_HSTART, `VERA_REG_HSTOP, `VERA_REG_VSTART, `VERA_REG_VSTOP};
        void'($urandom(79427));
        clk       = 1'b0;
        reset     = 1'b1;
        wb_adr    = '0;
        wb_dat_w  = '0;
        wb_sel    = '0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        frames    = 0;
        checked   = 0;
        check_en  = 0;
        irq_watch = 0;
        vera_model::reset_state();
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;

        // Reset values
        @(negedge clk);
        assert (irq_n_o) else report_failure("Error irq_n_o exp 1 got 0");
        assert (!wb_ack_o && !wb_stall_o) else
            report_failure("Bus acknowledge or stall is active after reset");
        assert ({vga_r_o, vga_g_o, vga_b_o, vga_hsync_o, vga_vsync_o} == '0) else
            report_failure("VGA pins are not all zero after reset");
        check_read(`VERA_REG_BORDER, 32'h0, "border");
        check_read(`VERA_REG_IEN, 32'h0, "ien");
        check_read(`VERA_REG_ISR, 32'h0, "isr");
        check_read(`VERA_REG_HSTOP, 32'd640, "hstop");
        check_read(`VERA_REG_VSTOP, 32'd480, "vstop");
        check_read(`VERA_REG_VIDEO, 32'h0, "video");

        // Register read-back and empty regions
        for (int i = 0; i < 8; i++) begin
            write_register(writable[i], $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            check_read({11'b0, writable[i]}, vera_model::read_reg(writable[i]),
                       $sformatf("reg_%h", writable[i]));
        end
        check_read(17'h00007, 32'h0, "unmapped_reg");
        check_read(17'h00500, 32'h0, "unmapped");
        check_read(17'h10000, 32'h0, "unmapped_high");
        check_read(`VERA_PAL_START + ($urandom % 256), 32'h0, "palette_read");

        // Palette, entry 0 and the border entry get a full colour first
        write_register(`VERA_REG_BORDER, $urandom);
        idx = vera_model::read_reg(`VERA_REG_BORDER);
        for (int i = 0; i < 2; i++) begin
            data = $urandom;
            bus_access(`VERA_PAL_START + (i == 0 ? 0 : idx), 1'b1, data, 4'h3, rd);
            vera_model::write_palette(i == 0 ? 8'h00 : idx, data, 4'h3);
        end
        for (int i = 0; i < 20; i++) begin
            idx  = (i % 4 == 0) ? 8'h00 : ((i % 4 == 1) ? idx : 8'($urandom));
            data = $urandom;
            sel  = $urandom;
            bus_access(`VERA_PAL_START + idx, 1'b1, data, sel, rd);
            vera_model::write_palette(idx, data, sel);
            idx = vera_model::read_reg(`VERA_REG_BORDER);
        end

        // Composed frame with interrupts disabled
        write_register(`VERA_REG_IEN, 32'h0);
        write_register(`VERA_REG_IRQLINE, $urandom % 525);
        write_register(`VERA_REG_ISR, 32'h3);
        data = $urandom % 320;
        write_register(`VERA_REG_HSTART, data);
        write_register(`VERA_REG_HSTOP, data + 1 + $urandom % 500);
        data = $urandom % 240;
        write_register(`VERA_REG_VSTART, data);
        write_register(`VERA_REG_VSTOP, data + 1 + $urandom % 300);
        write_register(`VERA_REG_VIDEO, vera_pkg::VIDEO_VGA);
        irq_watch = 1;
        f0 = frames;
        wait (frames >= f0 + 1);
        check_en = 1;
        wait (frames >= f0 + 2);
        check_en = 0;
        assert (checked > 0) else report_failure("Monitor did not check any pixel");
        check_read(`VERA_REG_ISR, 32'h3, "isr");
        irq_watch = 0;

        // Enabled interrupts
        write_register(`VERA_REG_ISR, 32'h3);
        write_register(`VERA_REG_IEN, 32'h3);
        wait (irq_n_o == 1'b0);
        rd = '0;
        while (rd[1:0] != 2'b11) begin
            bus_access(`VERA_REG_ISR, 1'b0, '0, 4'hF, rd);
        end
        assert (!irq_n_o) else report_failure("Error irq_n_o exp 0 got 1");
        write_register(`VERA_REG_ISR, 32'h3);
        check_read(`VERA_REG_ISR, 32'h0, "isr");
        @(negedge clk);
        assert (irq_n_o) else report_failure("Error irq_n_o exp 1 got 0");

        // Scanline read twice within one line
        for (int i = 0; i < 10; i++) begin
            bus_access(`VERA_REG_SCANLINE, 1'b0, '0, 4'hF, rd);
            first = rd;
            bus_access(`VERA_REG_SCANLINE, 1'b0, '0, 4'hF, rd);
            second = rd;
            assert (first < 525 && second < 525 &&
                    (second >= first || (first >= 520 && second < 5))) else
                report_failure($sformatf("Error scanline exp ordered got %h then %h",
                                         first, second));
            repeat ($urandom % 3000) @(posedge clk);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/vera_pkg.sv
rtl/vera_bus_if.sv
rtl/vera_wb_slave.sv
rtl/vera_regs.sv
rtl/palette_ram.sv
rtl/video_timing.sv
rtl/display_composer.sv
rtl/vera_top.sv
bench/vera_model.sv
bench/tb_vera.sv

//--- Bender.yml
package:
  name: vera_display

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vera_pkg.sv
      - rtl/vera_bus_if.sv
      - rtl/vera_wb_slave.sv
      - rtl/vera_regs.sv
      - rtl/palette_ram.sv
      - rtl/video_timing.sv
      - rtl/display_composer.sv
      - rtl/vera_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/vera_model.sv
      - bench/tb_vera.sv
